/* hw/conv_pkg.sv */
`default_nettype none

package conv_pkg;

	// one feature-map pixel as it arrives on the pixel stream.
	typedef logic signed [15:0] pixel_t;

	// one kernel weight as it arrives on the weight stream.
	typedef logic signed [15:0] weight_t;

	// full-precision pixel times weight.
	typedef logic signed [31:0] product_t;

	// window sum with eight guard bits for up to 256 taps.
	typedef logic signed [39:0] acc_t;

	typedef enum logic [1:0]
	{
		LOAD_WEIGHTS,
		STREAM,
		DRAIN
	} ctrl_state_t;

endpackage

`default_nettype wire

/* hw/window_line_buffer.sv */
`timescale 1ns/1ns
`default_nettype none

module window_line_buffer #(
	parameter int IFM_SIZE = 14,
	parameter int KERNEL_SIZE = 5
) (
	input wire clk,
	input wire reset,
	input wire shift,
	input wire conv_pkg::pixel_t pixel_in,
	output logic [KERNEL_SIZE*KERNEL_SIZE*$bits(conv_pkg::pixel_t)-1:0] window_taps
);

	localparam int PIX_W = $bits(conv_pkg::pixel_t);

	// enough history to span the window from its newest pixel back to the top-left one.
	localparam int CHAIN_LEN = (KERNEL_SIZE - 1) * IFM_SIZE + KERNEL_SIZE;

	// chain[0] is the newest pixel, chain[CHAIN_LEN-1] the oldest.
	conv_pkg::pixel_t chain [CHAIN_LEN];

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			for (int i = 0; i < CHAIN_LEN; i++)
			begin
				chain[i] <= '0;
			end
		end
		else if (shift)
		begin
			chain[0] <= pixel_in;
			for (int i = 1; i < CHAIN_LEN; i++)
			begin
				chain[i] <= chain[i-1];
			end
		end
	end

	// Window rows sit IFM_SIZE apart in the chain, so row r and column c of the
	// window is found (KERNEL_SIZE-1-r) lines and (KERNEL_SIZE-1-c) pixels back.
	for (genvar r = 0; r < KERNEL_SIZE; r++)
	begin : g_row
		for (genvar c = 0; c < KERNEL_SIZE; c++)
		begin : g_col
			assign window_taps[(r*KERNEL_SIZE+c)*PIX_W +: PIX_W] =
				chain[(KERNEL_SIZE-1-r)*IFM_SIZE + (KERNEL_SIZE-1-c)];
		end
	end

endmodule

`default_nettype wire

/* hw/conv_position_counter.sv */
`timescale 1ns/1ns
`default_nettype none

module conv_position_counter #(
	parameter int IFM_SIZE = 14,
	parameter int KERNEL_SIZE = 5
) (
	input wire clk,
	input wire reset,
	input wire weight_load,
	input wire pixel_shift,
	input wire frame_clear,
	output logic weights_full,
	output logic last_pixel,
	output logic window_complete
);

	localparam int WIDX_W = $clog2(KERNEL_SIZE*KERNEL_SIZE + 1);
	localparam int POS_W = $clog2(IFM_SIZE + 1);

	localparam logic [WIDX_W-1:0] LAST_WEIGHT = WIDX_W'(KERNEL_SIZE*KERNEL_SIZE - 1);
	localparam logic [POS_W-1:0] LAST_POS = POS_W'(IFM_SIZE - 1);
	localparam logic [POS_W-1:0] FIRST_FULL = POS_W'(KERNEL_SIZE - 1);

	logic [WIDX_W-1:0] weight_idx;
	logic [POS_W-1:0] col;
	logic [POS_W-1:0] row;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			weight_idx <= '0;
			col <= '0;
			row <= '0;
		end
		else if (frame_clear)
		begin
			weight_idx <= '0;
			col <= '0;
			row <= '0;
		end
		else
		begin
			if (weight_load)
				weight_idx <= weight_idx + 1'b1;
			if (pixel_shift)
			begin
				if (col == LAST_POS)
				begin
					col <= '0;
					row <= row + 1'b1; // row only moves on a line wrap.
				end
				else
					col <= col + 1'b1;
			end
		end
	end

	// flags describe the item being offered now, not the one already taken.
	assign weights_full = (weight_idx == LAST_WEIGHT);
	assign last_pixel = (row == LAST_POS) && (col == LAST_POS);
	assign window_complete = (row >= FIRST_FULL) && (col >= FIRST_FULL);

endmodule

`default_nettype wire

/* hw/conv_control_fsm.sv */
`timescale 1ns/1ns
`default_nettype none

module conv_control_fsm (
	input wire clk,
	input wire reset,
	input wire weight_valid,
	input wire pixel_valid,
	input wire advance,
	input wire weights_full,
	input wire last_pixel,
	input wire pipe_empty,
	output logic weight_ready,
	output logic pixel_ready,
	output logic weight_load,
	output logic pixel_shift,
	output logic frame_clear,
	output logic frame_done
);

	conv_pkg::ctrl_state_t state;
	conv_pkg::ctrl_state_t state_next;
	logic drain_done;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			state <= conv_pkg::LOAD_WEIGHTS;
		else
			state <= state_next;
	end

	always_comb
	begin
		state_next = state;
		case (state)
			conv_pkg::LOAD_WEIGHTS:
			begin
				if (weight_load && weights_full)
					state_next = conv_pkg::STREAM;
			end
			conv_pkg::STREAM:
			begin
				if (pixel_shift && last_pixel)
					state_next = conv_pkg::DRAIN;
			end
			conv_pkg::DRAIN:
			begin
				if (drain_done)
					state_next = conv_pkg::LOAD_WEIGHTS;
			end
			default:
			begin
				state_next = conv_pkg::LOAD_WEIGHTS;
			end
		endcase
	end

	assign weight_ready = (state == conv_pkg::LOAD_WEIGHTS);

	// a stalled result also freezes the window, so no pixel is taken then.
	assign pixel_ready = (state == conv_pkg::STREAM) && advance;

	assign weight_load = weight_valid && weight_ready;
	assign pixel_shift = pixel_valid && pixel_ready;

	// the last result has left the output register once the pipe is empty.
	assign drain_done = (state == conv_pkg::DRAIN) && pipe_empty;

	assign frame_clear = drain_done;
	assign frame_done = drain_done;

endmodule

`default_nettype wire

/* hw/window_mac.sv */
`timescale 1ns/1ns
`default_nettype none

module window_mac #(
	parameter int KERNEL_SIZE = 5
) (
	input wire clk,
	input wire reset,
	input wire weight_load,
	input wire conv_pkg::weight_t weight_in,
	input wire [KERNEL_SIZE*KERNEL_SIZE*$bits(conv_pkg::pixel_t)-1:0] window_taps,
	input wire pixel_shift,
	input wire window_complete,
	input wire result_ready,
	output logic result_valid,
	output conv_pkg::acc_t result_data,
	output logic advance,
	output logic pipe_empty
);

	localparam int TAPS = KERNEL_SIZE * KERNEL_SIZE;
	localparam int PIX_W = $bits(conv_pkg::pixel_t);

	conv_pkg::weight_t weights [TAPS];
	conv_pkg::pixel_t taps [TAPS];
	conv_pkg::product_t products [TAPS];
	conv_pkg::acc_t row_sum_next [KERNEL_SIZE];
	conv_pkg::acc_t row_sum [KERNEL_SIZE];
	conv_pkg::acc_t total_next;

	logic tag_in;
	logic tag_q;
	logic product_valid;
	logic row_valid;

	assign tag_in = pixel_shift && window_complete;

	for (genvar i = 0; i < TAPS; i++)
	begin : g_tap
		assign taps[i] = window_taps[i*PIX_W +: PIX_W];
	end

	// weights enter at the top, so after a full load the first one sits at tap 0.
	always_ff @(posedge clk)
	begin
		if (weight_load)
		begin
			for (int i = 0; i < TAPS - 1; i++)
			begin
				weights[i] <= weights[i+1];
			end
			weights[TAPS-1] <= weight_in;
		end
	end

	// the whole pipe holds still while the output waits on result_ready.
	assign advance = !result_valid || result_ready;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			tag_q <= 1'b0;
			product_valid <= 1'b0;
			row_valid <= 1'b0;
			result_valid <= 1'b0;
		end
		else if (advance)
		begin
			tag_q <= tag_in;
			product_valid <= tag_q;
			row_valid <= product_valid;
			result_valid <= row_valid;
		end
	end

	always_comb
	begin
		for (int r = 0; r < KERNEL_SIZE; r++)
		begin
			row_sum_next[r] = '0;
			for (int c = 0; c < KERNEL_SIZE; c++)
			begin
				row_sum_next[r] = row_sum_next[r] +
					conv_pkg::acc_t'(products[r*KERNEL_SIZE+c]);
			end
		end
	end

	always_comb
	begin
		total_next = '0;
		for (int r = 0; r < KERNEL_SIZE; r++)
		begin
			total_next = total_next + row_sum[r];
		end
	end

	// taps are still frozen on the window that tag_q marks when products are taken.
	always_ff @(posedge clk)
	begin
		if (advance)
		begin
			for (int i = 0; i < TAPS; i++)
			begin
				products[i] <= conv_pkg::product_t'(weights[i]) * conv_pkg::product_t'(taps[i]);
			end
			row_sum <= row_sum_next;
			result_data <= total_next;
		end
	end

	assign pipe_empty = !(tag_q || product_valid || row_valid || result_valid);

endmodule

`default_nettype wire

/* hw/conv_layer.sv */
`timescale 1ns/1ns
`default_nettype none

module conv_layer #(
	parameter int IFM_SIZE = 14,
	parameter int KERNEL_SIZE = 5
) (
	input wire clk,
	input wire reset,
	input wire weight_valid,
	input wire conv_pkg::weight_t weight_data,
	output logic weight_ready,
	input wire pixel_valid,
	input wire conv_pkg::pixel_t pixel_data,
	output logic pixel_ready,
	output logic result_valid,
	output conv_pkg::acc_t result_data,
	input wire result_ready,
	output logic frame_done
);

	logic weight_load;
	logic pixel_shift;
	logic frame_clear;
	logic weights_full;
	logic last_pixel;
	logic window_complete;
	logic advance;
	logic pipe_empty;
	logic [KERNEL_SIZE*KERNEL_SIZE*$bits(conv_pkg::pixel_t)-1:0] window_taps;

	conv_control_fsm u_control (
		.clk (clk),
		.reset (reset),
		.weight_valid (weight_valid),
		.pixel_valid (pixel_valid),
		.advance (advance),
		.weights_full (weights_full),
		.last_pixel (last_pixel),
		.pipe_empty (pipe_empty),
		.weight_ready (weight_ready),
		.pixel_ready (pixel_ready),
		.weight_load (weight_load),
		.pixel_shift (pixel_shift),
		.frame_clear (frame_clear),
		.frame_done (frame_done)
	);

	conv_position_counter #(
		.IFM_SIZE (IFM_SIZE),
		.KERNEL_SIZE (KERNEL_SIZE)
	) u_position (
		.clk (clk),
		.reset (reset),
		.weight_load (weight_load),
		.pixel_shift (pixel_shift),
		.frame_clear (frame_clear),
		.weights_full (weights_full),
		.last_pixel (last_pixel),
		.window_complete (window_complete)
	);

	window_line_buffer #(
		.IFM_SIZE (IFM_SIZE),
		.KERNEL_SIZE (KERNEL_SIZE)
	) u_line_buffer (
		.clk (clk),
		.reset (reset),
		.shift (pixel_shift),
		.pixel_in (pixel_data),
		.window_taps (window_taps)
	);

	window_mac #(
		.KERNEL_SIZE (KERNEL_SIZE)
	) u_mac (
		.clk (clk),
		.reset (reset),
		.weight_load (weight_load),
		.weight_in (weight_data),
		.window_taps (window_taps),
		.pixel_shift (pixel_shift),
		.window_complete (window_complete),
		.result_ready (result_ready),
		.result_valid (result_valid),
		.result_data (result_data),
		.advance (advance),
		.pipe_empty (pipe_empty)
	);

endmodule

`default_nettype wire

/* bench/conv_layer_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module conv_layer_tb;

	localparam int IFM_SIZE = 8;
	localparam int KERNEL_SIZE = 3;
	localparam int TAPS = KERNEL_SIZE * KERNEL_SIZE;
	localparam int PIXELS = IFM_SIZE * IFM_SIZE;
	localparam int OUT_SIZE = IFM_SIZE - KERNEL_SIZE + 1;
	localparam int FRAME_TIMEOUT = 20000;
	localparam int NUM_CASES = 7;

	localparam int W_ONE_HOT = 0;
	localparam int W_RAMP = 1;
	localparam int W_RANDOM = 2;

	localparam int P_RAMP = 0;
	localparam int P_CONST = 1;
	localparam int P_ALT = 2;
	localparam int P_RANDOM = 3;

	typedef struct packed {
		int weight_code;
		int hot_tap;
		int pixel_code;
		int stall_pct;
		int gap_pct;
	} frame_case_t;

	// weight code, hot tap, pixel code, result stall percent, pixel gap percent.
	frame_case_t cases [NUM_CASES] = '{
		'{W_ONE_HOT, 0, P_RAMP, 0, 0},
		'{W_ONE_HOT, 5, P_RAMP, 0, 0},
		'{W_ONE_HOT, 8, P_RAMP, 30, 20},
		'{W_RANDOM, 0, P_RANDOM, 0, 0},
		'{W_RAMP, 0, P_ALT, 40, 30},
		'{W_RANDOM, 0, P_CONST, 50, 50},
		'{W_RANDOM, 0, P_RANDOM, 70, 60}
	};

	logic clk;
	logic reset;
	logic weight_valid;
	conv_pkg::weight_t weight_data;
	logic weight_ready;
	logic pixel_valid;
	conv_pkg::pixel_t pixel_data;
	logic pixel_ready;
	logic result_valid;
	conv_pkg::acc_t result_data;
	logic result_ready;
	logic frame_done;

	integer seed = 32'h50d95d40;
	conv_pkg::weight_t weights [TAPS];
	conv_pkg::pixel_t pixels [PIXELS];
	conv_pkg::acc_t expected [$];

	conv_layer #(
		.IFM_SIZE (IFM_SIZE),
		.KERNEL_SIZE (KERNEL_SIZE)
	) UUT (
		.clk (clk),
		.reset (reset),
		.weight_valid (weight_valid),
		.weight_data (weight_data),
		.weight_ready (weight_ready),
		.pixel_valid (pixel_valid),
		.pixel_data (pixel_data),
		.pixel_ready (pixel_ready),
		.result_valid (result_valid),
		.result_data (result_data),
		.result_ready (result_ready),
		.frame_done (frame_done)
	);

	initial clk = 1'b0;
	always #20 clk = ~clk;

	task automatic stop_run(input string what);
		$display("%s", what);
		$display(">>> FAIL");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] want);
		if (got !== want)
			stop_run($sformatf("MISMATCH %s got %0h expected %0h", name, got, want));
	endtask

	function automatic bit roll_percent(input int pct);
		int r;
		r = $random(seed) % 100;
		if (r < 0)
			r = -r;
		return r < pct;
	endfunction

	// builds the frame data and the expected window sums in raster order.
	task automatic make_frame(input frame_case_t fc);
		longint sum;
		for (int i = 0; i < TAPS; i++)
		begin
			case (fc.weight_code)
				W_ONE_HOT: weights[i] = (i == fc.hot_tap) ? 16'sd1 : 16'sd0;
				W_RAMP: weights[i] = conv_pkg::weight_t'(i - TAPS / 2);
				default: weights[i] = conv_pkg::weight_t'($random(seed));
			endcase
		end
		for (int i = 0; i < PIXELS; i++)
		begin
			case (fc.pixel_code)
				P_RAMP: pixels[i] = conv_pkg::pixel_t'(i + 1);
				P_CONST: pixels[i] = 16'sh8000; // most negative pixel.
				P_ALT: pixels[i] = conv_pkg::pixel_t'(((i / IFM_SIZE + i % IFM_SIZE) % 2 == 0) ?
					1000 + i : -1000 - i);
				default: pixels[i] = conv_pkg::pixel_t'($random(seed));
			endcase
		end
		expected.delete();
		for (int y = 0; y < OUT_SIZE; y++)
		begin
			for (int x = 0; x < OUT_SIZE; x++)
			begin
				sum = 0;
				for (int r = 0; r < KERNEL_SIZE; r++)
				begin
					for (int c = 0; c < KERNEL_SIZE; c++)
					begin
						sum += longint'(weights[r*KERNEL_SIZE+c]) *
							longint'(pixels[(y+r)*IFM_SIZE + x + c]);
					end
				end
				expected.push_back(conv_pkg::acc_t'(sum));
			end
		end
	endtask

	task automatic run_frame(input int idx, input frame_case_t fc);
		int w_sent;
		int p_sent;
		int r_seen;
		int cycles;
		bit pix_taken;
		bit done_seen;
		bit held;
		conv_pkg::acc_t held_data;
		w_sent = 0;
		p_sent = 0;
		r_seen = 0;
		cycles = 0;
		done_seen = 1'b0;
		held = 1'b0;
		held_data = '0;
		make_frame(fc);
		while (!done_seen)
		begin
			@(posedge clk);
			cycles++;
			if (cycles > FRAME_TIMEOUT)
				stop_run($sformatf("timeout in case %0d, frame_done did not come after %0d results",
					idx, r_seen));
			// a stalled result must not move or vanish.
			if (held)
			begin
				check_value("result_valid", 64'(result_valid), 64'd1);
				check_value("result_data", 64'(result_data), 64'(held_data));
			end
			if (weight_valid && weight_ready)
				w_sent++;
			pix_taken = pixel_valid && pixel_ready;
			if (pix_taken)
				p_sent++;
			if (result_valid && result_ready)
			begin
				if (r_seen >= expected.size())
					stop_run($sformatf("case %0d produced more results than windows", idx));
				check_value("result_data", 64'(result_data), 64'(expected[r_seen]));
				r_seen++;
			end
			held = result_valid && !result_ready;
			held_data = result_data;
			if (frame_done)
			begin
				done_seen = 1'b1;
				if (r_seen != expected.size() || p_sent != PIXELS || w_sent != TAPS)
					stop_run($sformatf("case %0d ended early with %0d results and %0d pixels taken",
						idx, r_seen, p_sent));
			end
			if (w_sent < TAPS)
			begin
				weight_valid <= 1'b1;
				weight_data <= weights[w_sent];
			end
			else
				weight_valid <= 1'b0;
			if (!(pixel_valid && !pix_taken)) // an offered pixel waits until it is taken.
			begin
				if (p_sent < PIXELS && !roll_percent(fc.gap_pct))
				begin
					pixel_valid <= 1'b1;
					pixel_data <= pixels[p_sent];
				end
				else
					pixel_valid <= 1'b0;
			end
			result_ready <= !roll_percent(fc.stall_pct);
		end
		@(posedge clk);
		check_value("frame_done", 64'(frame_done), 64'd0);
		check_value("weight_ready", 64'(weight_ready), 64'd1);
		check_value("pixel_ready", 64'(pixel_ready), 64'd0);
	endtask

	initial
	begin
		reset = 1'b1;
		weight_valid = 1'b0;
		weight_data = '0;
		pixel_valid = 1'b0;
		pixel_data = '0;
		result_ready = 1'b0;
		repeat (10) @(posedge clk);
		reset <= 1'b0;
		@(posedge clk);
		check_value("weight_ready", 64'(weight_ready), 64'd1);
		check_value("pixel_ready", 64'(pixel_ready), 64'd0);
		check_value("result_valid", 64'(result_valid), 64'd0);
		check_value("frame_done", 64'(frame_done), 64'd0);
		for (int i = 0; i < NUM_CASES; i++)
		begin
			run_frame(i, cases[i]);
		end
		$display(">>> PASS");
		$finish;
	end

endmodule

`default_nettype wire

/* conv_layer.f */
hw/conv_pkg.sv
hw/window_line_buffer.sv
hw/conv_position_counter.sv
hw/conv_control_fsm.sv
hw/window_mac.sv
hw/conv_layer.sv
bench/conv_layer_tb.sv

/* Makefile */
# Verilator flow for the convolution engine.
# Any variable below can be overridden on the command line, e.g. make sim BUILD_DIR=build

VERILATOR ?= verilator
FILELIST ?= conv_layer.f
RTL_TOP ?= conv_layer
TB_TOP ?= conv_layer_tb
BUILD_DIR ?= obj_dir
VFLAGS ?= --timing
PASS_TEXT ?= >>> PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

# the run passes only if the pass line shows up in the simulator output.
sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TB_TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF '$(PASS_TEXT)'

clean:
	rm -rf $(BUILD_DIR)
